// ==== emu_stream.f ====
+incdir+source
source/emu_stream_pkg.sv
source/emulib_fifo.sv
source/emu_data_source.sv
source/emu_data_sink.sv
source/emu_stream_top.sv
tb/emu_stream_checker.sv
tb/emu_stream_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the emu_stream testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --timescale 1ns/1ns \
    --top-module emu_stream_tb \
    --Mdir obj_dir \
    -f emu_stream.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vemu_stream_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished cleanly"
exit 0

// ==== source/emu_data_sink.sv ====
`timescale 1ns/1ns

`include "emu_stream_macros.svh"

// Target-to-host write channel model
module emu_data_sink #(
    parameter int FIFO_DEPTH = `EMU_SINK_DEPTH
) (
    input  logic                   mdl_clk,
    input  logic                   rst_n,

    // Write token channel
    input  logic                   tk_write_valid,
    output logic                   tk_write_ready,
    input  logic                   wen,
    input  emu_stream_pkg::data_t  wdata,

    // Host read side
    input  logic                   sink_credit,
    output logic                   sink_valid,
    output emu_stream_pkg::data_t  sink_data,
    output emu_stream_pkg::cycle_t sink_cycle
);

    import emu_stream_pkg::*;

    cycle_t                      tk_count;
    logic [`EMU_CYCLE_WIDTH-1:0] credit_cnt;
    logic                        tk_done;
    logic                        push;
    logic                        xfer;
    logic                        wfull;
    logic                        rempty;
    sink_rec_t                   rec_in;
    sink_rec_t                   rec_out;

    assign tk_write_ready = !wfull;
    assign tk_done        = tk_write_valid && tk_write_ready;
    assign push           = tk_done && wen;

    // Stamp with the count before this token
    assign rec_in.data  = wdata;
    assign rec_in.cycle = tk_count;

    emulib_fifo #(
        .payload_t (sink_rec_t),
        .DEPTH     (FIFO_DEPTH)
    ) fifo_i (
        .mdl_clk   (mdl_clk),
        .rst_n     (rst_n),
        .winc      (push),
        .wdata     (rec_in),
        .rinc      (xfer),
        .rdata     (rec_out),
        .wfull     (wfull),
        .rempty    (rempty)
    );

    // Host takes the record in the same cycle
    assign sink_valid = (credit_cnt != '0) && !rempty;
    assign xfer       = sink_valid;
    assign sink_data  = rec_out.data;
    assign sink_cycle = rec_out.cycle;

    always_ff @(posedge mdl_clk or negedge rst_n) begin
        if (!rst_n) begin
            tk_count   <= '0;
            credit_cnt <= '0;
        end else begin
            if (tk_done) begin
                tk_count <= tk_count + 1'b1;  // Counts tokens with wen low too
            end
            case ({sink_credit, xfer})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

// ==== source/emu_data_source.sv ====
`timescale 1ns/1ns

`include "emu_stream_macros.svh"

// Host-to-target read channel model
module emu_data_source #(
    parameter int FIFO_DEPTH = `EMU_SOURCE_DEPTH
) (
    input  logic                  mdl_clk,
    input  logic                  rst_n,

    // Host write side
    input  logic                  source_wen,
    input  emu_stream_pkg::data_t source_wdata,
    output logic                  source_credit,

    // Read token channel
    input  logic                  tk_read_valid,
    output logic                  tk_read_ready,
    input  logic                  ren,
    output emu_stream_pkg::data_t rdata
);

    import emu_stream_pkg::*;

    logic rempty;
    logic tk_done;
    logic pop;

    // A token completes only when a word is waiting
    assign tk_read_ready = !rempty;
    assign tk_done       = tk_read_valid && tk_read_ready;
    assign pop           = tk_done && ren;  // ren low keeps the head

    emulib_fifo #(
        .payload_t (data_t),
        .DEPTH     (FIFO_DEPTH)
    ) fifo_i (
        .mdl_clk   (mdl_clk),
        .rst_n     (rst_n),
        .winc      (source_wen),
        .wdata     (source_wdata),
        .rinc      (pop),
        .rdata     (rdata),
        .wfull     (),
        .rempty    (rempty)
    );

    // One credit back to the host per consumed word
    always_ff @(posedge mdl_clk or negedge rst_n) begin
        if (!rst_n) begin
            source_credit <= 1'b0;
        end else begin
            source_credit <= pop;
        end
    end

endmodule

// ==== source/emu_stream_macros.svh ====
`ifndef EMU_STREAM_MACROS_SVH
`define EMU_STREAM_MACROS_SVH

// Payload word width
`define EMU_DATA_WIDTH 32

// Write-token counter width
`define EMU_CYCLE_WIDTH 16

// FIFO depths, also the host's initial credit counts
`define EMU_SOURCE_DEPTH 16
`define EMU_SINK_DEPTH 8

`endif

// ==== source/emu_stream_pkg.sv ====
`include "emu_stream_macros.svh"

package emu_stream_pkg;

    // One payload word
    typedef logic [`EMU_DATA_WIDTH-1:0] data_t;

    // Write-token count
    typedef logic [`EMU_CYCLE_WIDTH-1:0] cycle_t;

    // Sink record, data in the upper bits
    typedef struct packed {
        data_t  data;
        cycle_t cycle;
    } sink_rec_t;

endpackage

// ==== source/emu_stream_top.sv ====
`timescale 1ns/1ns

`include "emu_stream_macros.svh"

module emu_stream_top (
    input  logic                   mdl_clk,
    input  logic                   rst_n,

    // Host to source
    input  logic                   source_wen,
    input  emu_stream_pkg::data_t  source_wdata,
    output logic                   source_credit,

    // Target read tokens
    input  logic                   tk_read_valid,
    output logic                   tk_read_ready,
    input  logic                   ren,
    output emu_stream_pkg::data_t  rdata,

    // Target write tokens
    input  logic                   tk_write_valid,
    output logic                   tk_write_ready,
    input  logic                   wen,
    input  emu_stream_pkg::data_t  wdata,

    // Sink to host
    input  logic                   sink_credit,
    output logic                   sink_valid,
    output emu_stream_pkg::data_t  sink_data,
    output emu_stream_pkg::cycle_t sink_cycle
);

    emu_data_source #(
        .FIFO_DEPTH     (`EMU_SOURCE_DEPTH)
    ) emu_data_source_i (
        .mdl_clk        (mdl_clk),
        .rst_n          (rst_n),
        .source_wen     (source_wen),
        .source_wdata   (source_wdata),
        .source_credit  (source_credit),
        .tk_read_valid  (tk_read_valid),
        .tk_read_ready  (tk_read_ready),
        .ren            (ren),
        .rdata          (rdata)
    );

    emu_data_sink #(
        .FIFO_DEPTH     (`EMU_SINK_DEPTH)
    ) emu_data_sink_i (
        .mdl_clk        (mdl_clk),
        .rst_n          (rst_n),
        .tk_write_valid (tk_write_valid),
        .tk_write_ready (tk_write_ready),
        .wen            (wen),
        .wdata          (wdata),
        .sink_credit    (sink_credit),
        .sink_valid     (sink_valid),
        .sink_data      (sink_data),
        .sink_cycle     (sink_cycle)
    );

endmodule

// ==== source/emulib_fifo.sv ====
`timescale 1ns/1ns

module emulib_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 16
) (
    input  logic     mdl_clk,
    input  logic     rst_n,
    input  logic     winc,
    input  payload_t wdata,
    input  logic     rinc,
    output payload_t rdata,
    output logic     wfull,
    output logic     rempty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;
    logic [CNT_W-1:0] count;
    logic             do_write;
    logic             do_read;

    assign do_write = winc && !wfull;   // Overflow is dropped
    assign do_read  = rinc && !rempty;  // Underflow is dropped

    always_ff @(posedge mdl_clk) begin
        if (do_write) begin
            mem[wptr] <= wdata;
        end
    end

    always_ff @(posedge mdl_clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + 1'b1;
            end
            if (do_read) begin
                rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head of queue is always on the output
    assign rdata  = mem[rptr];
    assign wfull  = (count == CNT_W'(DEPTH));
    assign rempty = (count == '0);

endmodule

// ==== tb/emu_stream_checker.sv ====
`timescale 1ns/1ns

`include "emu_stream_macros.svh"

module emu_stream_checker (
    input logic mdl_clk,
    input logic rst_n,
    input logic tk_read_valid,
    input logic tk_read_ready,
    input logic ren,
    input logic source_credit,
    input logic tk_write_valid,
    input logic tk_write_ready,
    input logic wen,
    input logic sink_credit,
    input logic sink_valid
);

    localparam int SINK_DEPTH = `EMU_SINK_DEPTH;

    logic [`EMU_CYCLE_WIDTH-1:0] credits_held;  // Granted sink credits not yet used
    logic [`EMU_CYCLE_WIDTH-1:0] records_held;  // Records waiting in the sink
    logic                        rec_push;

    assign rec_push = tk_write_valid && tk_write_ready && wen;

    always_ff @(posedge mdl_clk or negedge rst_n) begin
        if (!rst_n) begin
            credits_held <= '0;
            records_held <= '0;
        end else begin
            case ({sink_credit, sink_valid})
                2'b10:   credits_held <= credits_held + 1'b1;
                2'b01:   credits_held <= credits_held - 1'b1;
                default: credits_held <= credits_held;
            endcase
            case ({rec_push, sink_valid})
                2'b10:   records_held <= records_held + 1'b1;
                2'b01:   records_held <= records_held - 1'b1;
                default: records_held <= records_held;
            endcase
        end
    end

    sink_valid_needs_credit: assert property (
        @(posedge mdl_clk) disable iff (!rst_n) sink_valid |-> (credits_held != '0)
    ) else $error("sink_valid asserted with no credit held");

    // Credit pulse follows a completed read token with ren by one cycle
    credit_follows_pop: assert property (
        @(posedge mdl_clk) disable iff (!rst_n)
        source_credit |-> $past(tk_read_valid && tk_read_ready && ren)
    ) else $error("source_credit without a pop in the previous cycle");

    ready_when_room: assert property (
        @(posedge mdl_clk) disable iff (!rst_n)
        (int'(records_held) < SINK_DEPTH) |-> tk_write_ready
    ) else $error("tk_write_ready low while the sink FIFO has room");

endmodule

// Source side only uses the credit rule, sink ports tied off
bind emu_data_source emu_stream_checker source_chk_i (
    .mdl_clk        (mdl_clk),
    .rst_n          (rst_n),
    .tk_read_valid  (tk_read_valid),
    .tk_read_ready  (tk_read_ready),
    .ren            (ren),
    .source_credit  (source_credit),
    .tk_write_valid (1'b0),
    .tk_write_ready (1'b1),
    .wen            (1'b0),
    .sink_credit    (1'b0),
    .sink_valid     (1'b0)
);

bind emu_data_sink emu_stream_checker sink_chk_i (
    .mdl_clk        (mdl_clk),
    .rst_n          (rst_n),
    .tk_read_valid  (1'b0),
    .tk_read_ready  (1'b0),
    .ren            (1'b0),
    .source_credit  (1'b0),
    .tk_write_valid (tk_write_valid),
    .tk_write_ready (tk_write_ready),
    .wen            (wen),
    .sink_credit    (sink_credit),
    .sink_valid     (sink_valid)
);

// ==== tb/emu_stream_tb.sv ====
`timescale 1ns/1ns

`include "emu_stream_macros.svh"

module emu_stream_tb;

    import emu_stream_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_CYCLES   = 3000;
    localparam int SRC_DEPTH    = `EMU_SOURCE_DEPTH;
    localparam int SNK_DEPTH    = `EMU_SINK_DEPTH;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES) * CLK_PERIOD + 1000;

    logic   mdl_clk;
    logic   rst_n;
    logic   source_wen;
    data_t  source_wdata;
    logic   source_credit;
    logic   tk_read_valid;
    logic   tk_read_ready;
    logic   ren;
    data_t  rdata;
    logic   tk_write_valid;
    logic   tk_write_ready;
    logic   wen;
    data_t  wdata;
    logic   sink_credit;
    logic   sink_valid;
    data_t  sink_data;
    cycle_t sink_cycle;

    int     seed = 32'hb1319e61;
    data_t  src_q[$];           // Words held by the source FIFO
    data_t  snk_data_q[$];
    cycle_t snk_cycle_q[$];
    cycle_t tk_cnt;
    int     host_credits;
    int     snk_credits;
    int     valid_total;
    int     credit_total;
    logic   pop_prev;

    emu_stream_top emu_stream_top_i (.*);

    initial begin
        mdl_clk = 1'b0;
        forever #(CLK_PERIOD / 2) mdl_clk = ~mdl_clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the simulation hung and did not finish in %0d ns", TIMEOUT_NS);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    task automatic report_mismatch(input string what);
        $display("FAIL %0t: %s", $time, what);
        $display("Some tests failed");
        $fatal(1, "stopping on first mismatch");
    endtask

    task automatic check_data(input string what, input data_t exp, input data_t got);
        if (got !== exp) begin
            report_mismatch($sformatf("%s expected %h got %h", what, exp, got));
        end
    endtask

    task automatic check_cycle(input string what, input cycle_t exp, input cycle_t got);
        if (got !== exp) begin
            report_mismatch($sformatf("%s expected %0d got %0d", what, exp, got));
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic got);
        if (got !== exp) begin
            report_mismatch($sformatf("%s expected %b got %b", what, exp, got));
        end
    endtask

    function automatic bit roll_percent(input int pct);
        int v;
        v = $random(seed) & 32'h7fffffff;
        return (v % 100) < pct;
    endfunction

    task automatic drive_inputs();
        source_wen = 1'b0;
        if (host_credits > 0 && roll_percent(50)) begin
            source_wen   = 1'b1;
            source_wdata = $random(seed);
            host_credits = host_credits - 1;  // Spent at the write
        end
        tk_read_valid  = roll_percent(55);
        ren            = roll_percent(70);
        tk_write_valid = roll_percent(60);
        wen            = roll_percent(75);
        wdata          = $random(seed);
        sink_credit    = roll_percent(25);  // Slow host lets the sink fill up
    endtask

    // Checks this cycle's outputs, then applies the coming clock edge to the model
    task automatic compare_and_advance();
        logic exp_rready;
        logic exp_wready;
        logic exp_svalid;
        logic pop_now;
        exp_rready = (src_q.size() != 0);
        exp_wready = (snk_data_q.size() < SNK_DEPTH);
        exp_svalid = (snk_credits > 0) && (snk_data_q.size() != 0);

        // Running totals taken from what the DUT returns
        if (source_credit) begin
            host_credits++;
        end
        if (sink_valid) begin
            valid_total++;
        end
        check_flag("host credits in range", 1'b1,
                   host_credits >= 0 && host_credits <= SRC_DEPTH);
        check_flag("sink transfers within credits", 1'b1, valid_total <= credit_total);

        check_flag("tk_read_ready", exp_rready, tk_read_ready);
        check_flag("source_credit", pop_prev, source_credit);
        check_flag("tk_write_ready", exp_wready, tk_write_ready);
        check_flag("sink_valid", exp_svalid, sink_valid);
        if (exp_rready) begin
            check_data("rdata head", src_q[0], rdata);
        end

        pop_now = tk_read_valid && exp_rready && ren;
        if (pop_now) begin
            void'(src_q.pop_front());
        end
        if (source_wen) begin
            src_q.push_back(source_wdata);
        end
        pop_prev = pop_now;

        if (exp_svalid) begin
            check_data("sink_data", snk_data_q[0], sink_data);
            check_cycle("sink_cycle", snk_cycle_q[0], sink_cycle);
            void'(snk_data_q.pop_front());
            void'(snk_cycle_q.pop_front());
            snk_credits--;
        end
        if (sink_credit) begin
            snk_credits++;
            credit_total++;
        end
        if (tk_write_valid && exp_wready) begin
            if (wen) begin
                snk_data_q.push_back(wdata);
                snk_cycle_q.push_back(tk_cnt);  // Count before this token
            end
            tk_cnt = tk_cnt + 1'b1;
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        source_wen     = 1'b0;
        source_wdata   = '0;
        tk_read_valid  = 1'b0;
        ren            = 1'b0;
        tk_write_valid = 1'b0;
        wen            = 1'b0;
        wdata          = '0;
        sink_credit    = 1'b0;
        tk_cnt         = '0;
        host_credits   = SRC_DEPTH;
        snk_credits    = 0;
        valid_total    = 0;
        credit_total   = 0;
        pop_prev       = 1'b0;

        repeat (RESET_CYCLES) @(posedge mdl_clk);
        #1;
        rst_n = 1'b1;

        @(negedge mdl_clk);
        check_flag("tk_read_ready after reset", 1'b0, tk_read_ready);
        check_flag("source_credit after reset", 1'b0, source_credit);
        check_flag("sink_valid after reset", 1'b0, sink_valid);
        check_flag("tk_write_ready after reset", 1'b1, tk_write_ready);

        repeat (NUM_CYCLES) begin
            @(posedge mdl_clk);
            #1;
            drive_inputs();
            @(negedge mdl_clk);
            compare_and_advance();
        end

        check_flag("records reached the host", 1'b1, valid_total > 0);
        $display("All tests passed");
        $finish;
    end

endmodule
